/* sources.f */
src/kdi_pkg.sv
src/kdi_req_arb.sv
src/kdi_key_regs.sv
src/kdi_ctrl_fsm.sv
src/kdi_top.sv
dv/kdi_checker.sv
dv/kdi_tb.sv

/* Bender.yml */
package:
  name: kdi

sources:
  # RTL, package first
  - src/kdi_pkg.sv
  - src/kdi_req_arb.sv
  - src/kdi_key_regs.sv
  - src/kdi_ctrl_fsm.sv
  - src/kdi_top.sv

  # Testbench
  - target: test
    files:
      - dv/kdi_checker.sv
      - dv/kdi_tb.sv

/* dv/kdi_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for kdi_top with two SRAM slots. Digest and entropy source
// are behavioral models with random stalls. Escalation runs last, since
// it ends all key traffic until reset.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module kdi_tb import kdi_pkg::*; ();

  localparam int                    NumSramSlots = 2;
  // Per-ack tests, the round robin order and escalation
  localparam int                    NumTests     = 11;
  localparam int                    LimitCycles  = NumTests * 400;
  localparam logic [BlockWidth-1:0] IvFlash      = 64'h6a09_e667_f3bc_c908;
  localparam logic [BlockWidth-1:0] IvSram       = 64'hbb67_ae85_84ca_a73b;
  localparam logic [BlockWidth-1:0] EntropyStart = 64'h0123_4567_89ab_0000;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   kdi_en_i;
  logic                   escalate_i;
  logic                   seed_valid_i;
  logic [SeedWidth-1:0]   flash_seed_i;
  logic [SeedWidth/2-1:0] sram_seed_i;
  logic [NumSramSlots:0]  key_req_i;
  logic [NumSramSlots:0]  key_ack_o;
  key_rsp_t               key_rsp_o;
  logic                   edn_req_o;
  logic                   edn_ack_i;
  logic [BlockWidth-1:0]  edn_data_i;
  logic                   dig_valid_o;
  logic                   dig_ready_i;
  digest_cmd_e            dig_cmd_o;
  digest_sel_e            dig_sel_o;
  logic [BlockWidth-1:0]  dig_data_o;
  logic                   dig_valid_i;
  logic [BlockWidth-1:0]  dig_data_i;
  logic                   fsm_err_o;

  integer                 seed;
  logic [BlockWidth-1:0]  dig_state;
  logic [BlockWidth-1:0]  edn_word;
  logic                   rr_check;
  logic                   done;
  int                     num_tests;
  int                     num_errs;

  kdi_top #(
    .NumSramSlots(NumSramSlots)
  ) dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .kdi_en_i     (kdi_en_i),
    .escalate_i   (escalate_i),
    .seed_valid_i (seed_valid_i),
    .flash_seed_i (flash_seed_i),
    .sram_seed_i  (sram_seed_i),
    .key_req_i    (key_req_i),
    .key_ack_o    (key_ack_o),
    .key_rsp_o    (key_rsp_o),
    .edn_req_o    (edn_req_o),
    .edn_ack_i    (edn_ack_i),
    .edn_data_i   (edn_data_i),
    .dig_valid_o  (dig_valid_o),
    .dig_ready_i  (dig_ready_i),
    .dig_cmd_o    (dig_cmd_o),
    .dig_sel_o    (dig_sel_o),
    .dig_data_o   (dig_data_o),
    .dig_valid_i  (dig_valid_i),
    .dig_data_i   (dig_data_i),
    .fsm_err_o    (fsm_err_o)
  );

  kdi_checker #(
    .NumSramSlots (NumSramSlots),
    .IvFlash      (IvFlash),
    .IvSram       (IvSram),
    .EntropyStart (EntropyStart)
  ) chk0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .key_ack_i    (key_ack_o),
    .key_rsp_i    (key_rsp_o),
    .seed_valid_i (seed_valid_i),
    .flash_seed_i (flash_seed_i),
    .sram_seed_i  (sram_seed_i),
    .escalate_i   (escalate_i),
    .fsm_err_i    (fsm_err_o),
    .rr_check_i   (rr_check),
    .done_i       (done),
    .num_tests_o  (num_tests),
    .num_errs_o   (num_errs)
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////////
  // Digest and entropy models
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    dig_valid_i <= 1'b0;
    edn_ack_i   <= 1'b0;
    // Ready about three cycles in four
    dig_ready_i <= (($random(seed) & 3) != 0);
    if (dig_valid_o && dig_ready_i) begin
      case (dig_cmd_o)
        DigestInit: begin
          dig_state <= (dig_sel_o == SramDataSel) ? IvSram : IvFlash;
        end
        DigestFinal: begin
          dig_valid_i <= 1'b1;
          dig_data_i  <= dig_state;
        end
        // Load and Run both fold the block in
        default: begin
          dig_state <= dig_state ^ dig_data_o;
        end
      endcase
    end
    // Random delay before each entropy ack, words count up
    if (edn_req_o && !edn_ack_i && (($random(seed) & 3) == 0)) begin
      edn_ack_i  <= 1'b1;
      edn_data_i <= edn_word;
      edn_word   <= edn_word + 64'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////

  task automatic load_seeds(input logic valid);
    logic [SeedWidth-1:0] f;
    logic [SeedWidth/2-1:0] s;
    for (int i = 0; i < SeedWidth / 32; i++) begin
      f[i*32 +: 32] = $random(seed);
    end
    for (int i = 0; i < SeedWidth / 64; i++) begin
      s[i*32 +: 32] = $random(seed);
    end
    @(posedge clk_i);
    flash_seed_i <= f;
    sram_seed_i  <= s;
    seed_valid_i <= valid;
  endtask

  // Each request is held until its own ack, then dropped
  task automatic request_keys(input logic [NumSramSlots:0] mask);
    logic [NumSramSlots:0] pending;
    pending = mask;
    @(posedge clk_i);
    key_req_i <= pending;
    while (pending != '0) begin
      @(posedge clk_i);
      pending = pending & ~key_ack_o;
      key_req_i <= pending;
    end
  endtask

  initial begin
    seed         = 44679;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    kdi_en_i     = 1'b0;
    escalate_i   = 1'b0;
    seed_valid_i = 1'b0;
    flash_seed_i = '0;
    sram_seed_i  = '0;
    key_req_i    = '0;
    edn_ack_i    = 1'b0;
    edn_data_i   = '0;
    dig_ready_i  = 1'b0;
    dig_valid_i  = 1'b0;
    dig_data_i   = '0;
    dig_state    = '0;
    edn_word     = EntropyStart;
    rr_check     = 1'b0;
    done         = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni   <= 1'b1;
    kdi_en_i <= 1'b1;

    // Valid seeds on flash and both slots
    load_seeds(1'b1);
    request_keys(3'b001);
    load_seeds(1'b1);
    request_keys(3'b010);
    load_seeds(1'b1);
    request_keys(3'b100);

    // Invalid seed, flash and one slot
    load_seeds(1'b0);
    request_keys(3'b001);
    load_seeds(1'b0);
    request_keys(3'b100);

    // Flash grant first, then all three at once
    load_seeds(1'b1);
    request_keys(3'b001);
    rr_check <= 1'b1;
    request_keys(3'b111);
    rr_check <= 1'b0;

    // Escalate once the pending request reaches the digest
    load_seeds(1'b1);
    @(posedge clk_i);
    key_req_i <= 3'b100;
    do begin
      @(posedge clk_i);
    end while (!dig_valid_o);
    escalate_i <= 1'b1;
    repeat (100) @(posedge clk_i);

    done <= 1'b1;
    repeat (2) @(posedge clk_i);
    $display("Tests finished: %0d, failed: %0d", num_tests, num_errs);
    if (num_errs == 0 && num_tests == NumTests) begin
      $display("Simulation completed successfully");
    end else begin
      if (num_tests != NumTests) begin
        $display("Only %0d of %0d tests finished", num_tests, NumTests);
      end
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (LimitCycles) @(posedge clk_i);
    $display("Timeout: tests did not finish within %0d clock cycles", LimitCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* dv/kdi_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Scoreboard for kdi_top. Entropy words are assumed to count up by one
// from EntropyStart, and no word may be drawn outside an acked request
// until escalation.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module kdi_checker import kdi_pkg::*; #(
  parameter int                    NumSramSlots = 2,
  parameter logic [BlockWidth-1:0] IvFlash      = '0,
  parameter logic [BlockWidth-1:0] IvSram       = '0,
  parameter logic [BlockWidth-1:0] EntropyStart = '0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [NumSramSlots:0]  key_ack_i,
  input  key_rsp_t               key_rsp_i,
  input  logic                   seed_valid_i,
  input  logic [SeedWidth-1:0]   flash_seed_i,
  input  logic [SeedWidth/2-1:0] sram_seed_i,
  input  logic                   escalate_i,
  input  logic                   fsm_err_i,
  input  logic                   rr_check_i,
  input  logic                   done_i,
  output int                     num_tests_o,
  output int                     num_errs_o
);

  localparam int NumReq = NumSramSlots + 1;

  logic [BlockWidth-1:0] next_word;
  int                    rr_order[$];
  logic                  rr_q;
  logic                  esc_q;
  logic                  esc_seen;
  logic                  esc_bad;
  logic                  reported;

  initial begin
    next_word   = EntropyStart;
    num_tests_o = 0;
    num_errs_o  = 0;
    rr_q        = 1'b0;
    esc_q       = 1'b0;
    esc_seen    = 1'b0;
    esc_bad     = 1'b0;
    reported    = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////////

  // Init loads the IV, Load and Run xor a block, Final returns the state
  function automatic key_rsp_t expected_rsp(input logic                  sram,
                                            input logic                  sv,
                                            input logic [SeedWidth-1:0]  seed,
                                            input logic [BlockWidth-1:0] word0);
    key_rsp_t              rsp;
    logic [BlockWidth-1:0] acc;
    logic [BlockWidth-1:0] word;
    word = word0;
    for (int h = 0; h < NumKeyBlocks; h++) begin
      acc = sram ? IvSram : IvFlash;
      // Invalid seed means zero blocks, so the IV passes unchanged
      if (sv) begin
        acc = acc ^ seed[2*h*BlockWidth +: BlockWidth];
        acc = acc ^ seed[(2*h+1)*BlockWidth +: BlockWidth];
      end
      // SRAM halves fold in two fresh entropy words
      if (sram) begin
        acc  = acc ^ word ^ (word + 64'd1);
        word = word + 64'd2;
      end
      rsp.key[h*BlockWidth +: BlockWidth] = acc;
    end
    // Nonce words follow the ones used in the digest
    rsp.nonce      = {word + 64'd1, word};
    rsp.seed_valid = sv;
    return rsp;
  endfunction

  function automatic bit field_ok(input string name, input string field,
                                  input logic [KeyWidth-1:0] exp,
                                  input logic [KeyWidth-1:0] act);
    if (exp !== act) begin
      $display("ERR %s %s: expected %0h actual %0h", name, field, exp, act);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Per-test checks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_ack();
    key_rsp_t exp;
    string    name;
    string    kind;
    bit       ok;
    int       idx;
    int       hits;
    logic     sram;
    ok   = 1'b1;
    idx  = 0;
    hits = 0;
    for (int i = 0; i < NumReq; i++) begin
      if (key_ack_i[i]) begin
        idx  = i;
        hits = hits + 1;
      end
    end
    sram = (idx != 0);
    num_tests_o = num_tests_o + 1;
    kind = sram ? $sformatf("sram_slot%0d", idx - 1) : "flash";
    name = $sformatf("test%0d_%s%s", num_tests_o, kind,
                     seed_valid_i ? "" : "_invalid_seed");
    if (hits != 1) begin
      $display("%s: more than one acknowledge in the same cycle", name);
      ok = 1'b0;
    end
    exp = expected_rsp(sram, seed_valid_i,
                       sram ? {sram_seed_i, sram_seed_i} : flash_seed_i, next_word);
    // Flash uses two words, SRAM two per key half plus two
    next_word = next_word + (sram ? 64'd6 : 64'd2);
    ok &= field_ok(name, "key", exp.key, key_rsp_i.key);
    ok &= field_ok(name, "nonce", exp.nonce, key_rsp_i.nonce);
    ok &= field_ok(name, "seed_valid", exp.seed_valid, key_rsp_i.seed_valid);
    if (rr_check_i) begin
      rr_order.push_back(idx);
    end
    if (ok) begin
      $display("PASS %s", name);
    end else begin
      num_errs_o = num_errs_o + 1;
      $display("FAIL %s", name);
    end
  endtask

  // After a flash grant the search starts at slot 0 and wraps to flash
  task automatic check_order();
    bit ok;
    num_tests_o = num_tests_o + 1;
    ok = 1'b1;
    if (rr_order.size() != NumReq) begin
      $display("test%0d_round_robin: got %0d acknowledges instead of %0d",
               num_tests_o, rr_order.size(), NumReq);
      ok = 1'b0;
    end
    for (int k = 0; k < rr_order.size(); k++) begin
      if (rr_order[k] != (k + 1) % NumReq) begin
        $display("ERR test%0d_round_robin: expected %0d actual %0d",
                 num_tests_o, (k + 1) % NumReq, rr_order[k]);
        ok = 1'b0;
      end
    end
    rr_order.delete();
    if (ok) begin
      $display("PASS test%0d_round_robin", num_tests_o);
    end else begin
      num_errs_o = num_errs_o + 1;
      $display("FAIL test%0d_round_robin", num_tests_o);
    end
  endtask

  task automatic report_escalation();
    num_tests_o = num_tests_o + 1;
    if (!esc_seen) begin
      $display("FAIL test%0d_escalation: escalation was never applied", num_tests_o);
      num_errs_o = num_errs_o + 1;
    end else if (esc_bad) begin
      $display("FAIL test%0d_escalation", num_tests_o);
      num_errs_o = num_errs_o + 1;
    end else begin
      $display("PASS test%0d_escalation", num_tests_o);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (key_ack_i != '0) begin
        // Pending request must stay unanswered once escalated
        if (esc_seen) begin
          $display("An acknowledge arrived after escalation");
          esc_bad = 1'b1;
        end else begin
          check_ack();
        end
      end
      // Error flag stays low until escalation
      if (!esc_seen && fsm_err_i) begin
        $display("fsm_err_o is high although no escalation was applied");
        esc_bad = 1'b1;
      end
      // Error flag is due one cycle after escalation is seen
      if (esc_q && !fsm_err_i) begin
        $display("fsm_err_o is low although escalation was applied");
        esc_bad = 1'b1;
      end
      if (rr_q && !rr_check_i) begin
        check_order();
      end
      if (done_i && !reported) begin
        report_escalation();
        reported = 1'b1;
      end
      esc_seen = esc_seen | escalate_i;
      esc_q    = escalate_i;
      rr_q     = rr_check_i;
    end
  end

endmodule

/* src/kdi_top.sv */
////////////////////////////////////////////////////////////////////////////
// Key derivation top level. Requester 0 is the flash data key, 1 and up
// are SRAM slots. All requesters share one response bus, valid with ack.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module kdi_top import kdi_pkg::*; #(
  parameter int NumSramSlots = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   kdi_en_i,
  input  logic                   escalate_i,
  input  logic                   seed_valid_i,
  input  logic [SeedWidth-1:0]   flash_seed_i,
  input  logic [SeedWidth/2-1:0] sram_seed_i,
  input  logic [NumSramSlots:0]  key_req_i,
  output logic [NumSramSlots:0]  key_ack_o,
  output key_rsp_t               key_rsp_o,
  // Entropy source
  output logic                   edn_req_o,
  input  logic                   edn_ack_i,
  input  logic [BlockWidth-1:0]  edn_data_i,
  // Digest datapath
  output logic                   dig_valid_o,
  input  logic                   dig_ready_i,
  output digest_cmd_e            dig_cmd_o,
  output digest_sel_e            dig_sel_o,
  output logic [BlockWidth-1:0]  dig_data_o,
  input  logic                   dig_valid_i,
  input  logic [BlockWidth-1:0]  dig_data_i,
  output logic                   fsm_err_o
);

  req_bundle_t req_bundle;
  logic        req_valid;
  logic        req_done;
  logic        key_we;
  logic        nonce_we;
  logic        seed_valid_we;
  logic        entropy_sel;
  logic [1:0]  seed_idx;
  logic        entropy_idx;

  kdi_req_arb #(
    .NumSramSlots(NumSramSlots)
  ) u_req_arb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .key_req_i    (key_req_i),
    .seed_valid_i (seed_valid_i),
    .flash_seed_i (flash_seed_i),
    .sram_seed_i  (sram_seed_i),
    .req_done_i   (req_done),
    .key_ack_o    (key_ack_o),
    .req_valid_o  (req_valid),
    .req_bundle_o (req_bundle)
  );

  kdi_ctrl_fsm u_ctrl_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .kdi_en_i         (kdi_en_i),
    .escalate_i       (escalate_i),
    .req_valid_i      (req_valid),
    .ingest_entropy_i (req_bundle.ingest_entropy),
    .edn_ack_i        (edn_ack_i),
    .dig_ready_i      (dig_ready_i),
    .dig_valid_i      (dig_valid_i),
    .req_done_o       (req_done),
    .edn_req_o        (edn_req_o),
    .dig_valid_o      (dig_valid_o),
    .dig_cmd_o        (dig_cmd_o),
    .key_we_o         (key_we),
    .nonce_we_o       (nonce_we),
    .seed_valid_we_o  (seed_valid_we),
    .entropy_sel_o    (entropy_sel),
    .seed_idx_o       (seed_idx),
    .entropy_idx_o    (entropy_idx),
    .fsm_err_o        (fsm_err_o)
  );

  kdi_key_regs u_key_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_bundle_i    (req_bundle),
    .edn_data_i      (edn_data_i),
    .dig_data_i      (dig_data_i),
    .key_we_i        (key_we),
    .nonce_we_i      (nonce_we),
    .seed_valid_we_i (seed_valid_we),
    .entropy_sel_i   (entropy_sel),
    .seed_idx_i      (seed_idx),
    .entropy_idx_i   (entropy_idx),
    .dig_data_o      (dig_data_o),
    .dig_sel_o       (dig_sel_o),
    .key_rsp_o       (key_rsp_o)
  );

endmodule

/* src/kdi_ctrl_fsm.sv */
////////////////////////////////////////////////////////////////////////////
// Key derivation control FSM. Escalation is terminal until reset, and an
// open entropy request is kept up until its ack even in the error state.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module kdi_ctrl_fsm import kdi_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        kdi_en_i,
  input  logic        escalate_i,
  input  logic        req_valid_i,
  input  logic        ingest_entropy_i,
  input  logic        edn_ack_i,
  input  logic        dig_ready_i,
  input  logic        dig_valid_i,
  output logic        req_done_o,
  output logic        edn_req_o,
  output logic        dig_valid_o,
  output digest_cmd_e dig_cmd_o,
  output logic        key_we_o,
  output logic        nonce_we_o,
  output logic        seed_valid_we_o,
  output logic        entropy_sel_o,
  output logic [1:0]  seed_idx_o,
  output logic        entropy_idx_o,
  output logic        fsm_err_o
);

  typedef enum logic [3:0] {
    ResetSt, IdleSt, DigClrSt, DigLoadSt, FetchEntropySt, DigEntropySt,
    DigFinSt, DigWaitSt, FetchNonceSt, FinishSt, ErrorSt
  } state_e;

  state_e     state_d, state_q;
  logic [1:0] seed_cnt_q;
  logic       entropy_cnt_q;
  logic       seed_cnt_en, seed_cnt_clr;
  logic       entropy_cnt_en, entropy_cnt_clr;
  logic       edn_req_d, edn_req_q;

  //////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    seed_cnt_en     = 1'b0;
    seed_cnt_clr    = 1'b0;
    entropy_cnt_en  = 1'b0;
    entropy_cnt_clr = 1'b0;
    // Open request stays up until acked
    edn_req_d       = edn_req_q & ~edn_ack_i;
    req_done_o      = 1'b0;
    dig_valid_o     = 1'b0;
    dig_cmd_o       = DigestLoad;
    key_we_o        = 1'b0;
    nonce_we_o      = 1'b0;
    seed_valid_we_o = 1'b0;
    entropy_sel_o   = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Hold here until the block is enabled
      ResetSt: begin
        if (kdi_en_i) begin
          state_d = IdleSt;
        end
      end
      IdleSt: begin
        if (req_valid_i) begin
          state_d         = DigClrSt;
          seed_cnt_clr    = 1'b1;
          entropy_cnt_clr = 1'b1;
        end
      end
      // Revert digest state to the IV
      DigClrSt: begin
        dig_valid_o = 1'b1;
        dig_cmd_o   = DigestInit;
        if (dig_ready_i) begin
          state_d = DigLoadSt;
        end
      end
      // Even seed block loads, odd block runs a round
      DigLoadSt: begin
        dig_valid_o = 1'b1;
        if (seed_cnt_q[0]) begin
          dig_cmd_o = DigestRun;
          if (dig_ready_i) begin
            state_d = ingest_entropy_i ? FetchEntropySt : DigFinSt;
          end
        end else if (dig_ready_i) begin
          seed_cnt_en = 1'b1;
        end
      end
      // Two entropy words, staged in the nonce register
      FetchEntropySt: begin
        edn_req_d = ~(edn_ack_i & entropy_cnt_q);
        if (edn_ack_i) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q) begin
            state_d         = DigEntropySt;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      DigEntropySt: begin
        dig_valid_o   = 1'b1;
        entropy_sel_o = 1'b1;
        if (entropy_cnt_q) begin
          dig_cmd_o = DigestRun;
          if (dig_ready_i) begin
            state_d         = DigFinSt;
            entropy_cnt_clr = 1'b1;
          end
        end else if (dig_ready_i) begin
          entropy_cnt_en = 1'b1;
        end
      end
      DigFinSt: begin
        dig_valid_o = 1'b1;
        dig_cmd_o   = DigestFinal;
        if (dig_ready_i) begin
          state_d = DigWaitSt;
        end
      end
      // Store the result, then second half or nonce
      DigWaitSt: begin
        if (dig_valid_i) begin
          key_we_o = 1'b1;
          if (seed_cnt_q == 2'd1) begin
            seed_cnt_en = 1'b1;
            state_d     = DigClrSt;
          end else begin
            seed_cnt_clr    = 1'b1;
            seed_valid_we_o = 1'b1;
            state_d         = FetchNonceSt;
          end
        end
      end
      FetchNonceSt: begin
        edn_req_d = ~(edn_ack_i & entropy_cnt_q);
        if (edn_ack_i) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q) begin
            state_d         = FinishSt;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      FinishSt: begin
        req_done_o = 1'b1;
        state_d    = IdleSt;
      end
      // Terminal
      ErrorSt: begin
        fsm_err_o = 1'b1;
      end
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    if (escalate_i) begin
      state_d = ErrorSt;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ResetSt;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= 1'b0;
      edn_req_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      edn_req_q <= edn_req_d;
      if (seed_cnt_clr) begin
        seed_cnt_q <= '0;
      end else if (seed_cnt_en) begin
        seed_cnt_q <= seed_cnt_q + 2'd1;
      end
      if (entropy_cnt_clr) begin
        entropy_cnt_q <= 1'b0;
      end else if (entropy_cnt_en) begin
        entropy_cnt_q <= ~entropy_cnt_q;
      end
    end
  end

  assign edn_req_o     = edn_req_q;
  assign seed_idx_o    = seed_cnt_q;
  assign entropy_idx_o = entropy_cnt_q;

  // Entropy request is never withdrawn without an ack
  EdnReqHold_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_o && !edn_ack_i |=> edn_req_o);

  // Idle means nothing is pending towards digest or entropy source
  IdleQuiet_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == IdleSt |-> !dig_valid_o && !edn_req_o);

endmodule

/* src/kdi_key_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Key, nonce and seed-valid registers plus the digest input mux. Entropy
// words for SRAM keys are staged in the nonce register, so the response
// is only meaningful in the ack cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module kdi_key_regs import kdi_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  req_bundle_t           req_bundle_i,
  input  logic [BlockWidth-1:0] edn_data_i,
  input  logic [BlockWidth-1:0] dig_data_i,
  input  logic                  key_we_i,
  input  logic                  nonce_we_i,
  input  logic                  seed_valid_we_i,
  input  logic                  entropy_sel_i,
  input  logic [1:0]            seed_idx_i,
  input  logic                  entropy_idx_i,
  output logic [BlockWidth-1:0] dig_data_o,
  output digest_sel_e           dig_sel_o,
  output key_rsp_t              key_rsp_o
);

  logic [NumKeyBlocks-1:0][BlockWidth-1:0]    key_q;
  logic [NumEntropyWords-1:0][BlockWidth-1:0] nonce_q;
  logic                                       seed_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q        <= KeyInitDefault;
      nonce_q      <= NonceInitDefault;
      seed_valid_q <= 1'b0;
    end else begin
      // Upper seed index bit names the key half being finished
      if (key_we_i) begin
        key_q[seed_idx_i[1]] <= dig_data_i;
      end
      if (nonce_we_i) begin
        nonce_q[entropy_idx_i] <= edn_data_i;
      end
      if (seed_valid_we_i) begin
        seed_valid_q <= req_bundle_i.seed_valid;
      end
    end
  end

  // Digest input block
  // entropy word, seed block, or zero for an invalid seed
  always_comb begin
    if (entropy_sel_i) begin
      dig_data_o = nonce_q[entropy_idx_i];
    end else if (req_bundle_i.seed_valid) begin
      dig_data_o = req_bundle_i.seed[seed_idx_i];
    end else begin
      dig_data_o = '0;
    end
  end

  assign dig_sel_o = req_bundle_i.digest_sel;

  assign key_rsp_o = '{key:        key_q,
                       nonce:      nonce_q,
                       seed_valid: seed_valid_q};

endmodule

/* src/kdi_req_arb.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter over the flash requester (index 0) and the SRAM
// slots. Needs NumSramSlots >= 1. One request in flight at a time.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module kdi_req_arb import kdi_pkg::*; #(
  parameter int NumSramSlots = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [NumSramSlots:0]     key_req_i,
  input  logic                      seed_valid_i,
  input  logic [SeedWidth-1:0]      flash_seed_i,
  input  logic [SeedWidth/2-1:0]    sram_seed_i,
  input  logic                      req_done_i,
  output logic [NumSramSlots:0]     key_ack_o,
  output logic                      req_valid_o,
  output req_bundle_t               req_bundle_o
);

  localparam int NumReq = NumSramSlots + 1;
  localparam int IdxW   = $clog2(NumReq);

  req_bundle_t       bundles [NumReq];
  logic [NumReq-1:0] req_masked;
  logic [NumReq-1:0] gnt_q;
  logic [NumReq-1:0] ack_q;
  logic [IdxW-1:0]   gnt_idx_q;
  logic [IdxW-1:0]   pick_idx;
  logic              pick_found;
  logic              valid_q;

  // Flash data key, no entropy, full 256-bit seed
  assign bundles[0] = '{ingest_entropy: 1'b0,
                        digest_sel:     FlashDataSel,
                        seed_valid:     seed_valid_i,
                        seed:           flash_seed_i};

  // SRAM slots reuse the 128-bit seed for both halves
  for (genvar k = 1; k < NumReq; k++) begin : gen_sram_bundle
    assign bundles[k] = '{ingest_entropy: 1'b1,
                          digest_sel:     SramDataSel,
                          seed_valid:     seed_valid_i,
                          seed:           {sram_seed_i, sram_seed_i}};
  end

  // Hide a requester in the cycle right after its ack
  assign req_masked = key_req_i & ~ack_q;

  // Search upward starting after the last winner
  always_comb begin : p_pick
    int cand;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int i = 1; i <= NumReq; i++) begin
      cand = (int'(gnt_idx_q) + i) % NumReq;
      if (!pick_found && req_masked[cand]) begin
        pick_found = 1'b1;
        pick_idx   = IdxW'(cand);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      gnt_q     <= '0;
      ack_q     <= '0;
      // Start the search at the flash requester
      gnt_idx_q <= IdxW'(NumReq - 1);
    end else begin
      ack_q <= key_ack_o;
      if (valid_q) begin
        if (req_done_i) begin
          valid_q <= 1'b0;
          gnt_q   <= '0;
        end
      end else if (pick_found) begin
        valid_q   <= 1'b1;
        gnt_q     <= NumReq'(1) << pick_idx;
        gnt_idx_q <= pick_idx;
      end
    end
  end

  assign key_ack_o    = gnt_q & {NumReq{req_done_i}};
  assign req_valid_o  = valid_q;
  assign req_bundle_o = bundles[gnt_idx_q];

  // Grant is one-hot exactly while a request is in flight
  GntOneHot_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_q) && (req_valid_o == (gnt_q != '0)));

  // Grant and valid hold until the FSM reports completion
  GntStable_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o && !req_done_i |=> req_valid_o && $stable(gnt_q));

endmodule

/* src/kdi_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths, digest commands and request/response types for the key
// derivation block. Seed, key and nonce widths must be multiples of the
// 64-bit digest block.
////////////////////////////////////////////////////////////////////////////

package kdi_pkg;

  // Digest block and entropy word width
  parameter int BlockWidth = 64;
  parameter int KeyWidth   = 128;
  parameter int SeedWidth  = 256;
  parameter int NonceWidth = 128;

  // Block counts derived from the widths above
  parameter int NumKeyBlocks    = KeyWidth / BlockWidth;
  parameter int NumSeedBlocks   = SeedWidth / BlockWidth;
  parameter int NumEntropyWords = NonceWidth / BlockWidth;

  // Key and nonce register contents after reset
  parameter logic [KeyWidth-1:0]   KeyInitDefault   = 128'h5a3c_96e1_0f27_b84d_c163_7e92_a4d8_3b05;
  parameter logic [NonceWidth-1:0] NonceInitDefault = 128'h8e41_d20b_7c95_3fa6_1b68_e4c7_52f0_9d3a;

  // Commands sent with each block to the digest datapath
  typedef enum logic [1:0] {
    DigestInit  = 2'd0,
    DigestLoad  = 2'd1,
    DigestRun   = 2'd2,
    DigestFinal = 2'd3
  } digest_cmd_e;

  // Picks the IV constant inside the digest datapath
  typedef enum logic {
    FlashDataSel = 1'b0,
    SramDataSel  = 1'b1
  } digest_sel_e;

  // Per-request configuration, built by the arbiter
  typedef struct packed {
    logic                                     ingest_entropy;
    digest_sel_e                              digest_sel;
    logic                                     seed_valid;
    logic [NumSeedBlocks-1:0][BlockWidth-1:0] seed;
  } req_bundle_t;

  // Response shared by all requesters
  typedef struct packed {
    logic [KeyWidth-1:0]   key;
    logic [NonceWidth-1:0] nonce;
    logic                  seed_valid;
  } key_rsp_t;

endpackage
